// File: design/jtag_macros.svh
`ifndef JTAG_MACROS_SVH
`define JTAG_MACROS_SVH

// Command FIFO depth and the host's starting credit count
`define JTAG_FIFO_DEPTH 4

// Clock cycles each command word stays on the pins
`define JTAG_HOLD_CYCLES 4

// Response credits held by the pin driver after reset
`define JTAG_RSP_CREDITS 2

// Idle cycles with an empty command FIFO before the timeout pulse
`define JTAG_TIMEOUT_COUNT 40

// Instruction codes
`define JTAG_IR_IDCODE 4'b0001
`define JTAG_IR_USER   4'b1000
`define JTAG_IR_BYPASS 4'b1111

`define JTAG_IDCODE 32'h4A55_0C3B // Bit 0 is always 1

`endif

// File: design/jtag_pkg.sv
`default_nettype none

package jtag_pkg;

        // Upstream command word with tck in bit 0
        typedef struct packed {
                logic tms;
                logic tdi;
                logic trst;
                logic tck;
        } jtag_cmd_t;

        // Pin levels from the driver to the target
        typedef struct packed {
                logic tck;
                logic tms;
                logic tdi;
                logic trst;
        } jtag_pins_t;

        typedef struct packed {
                logic tdo; // Sampled on a rising TCK command
        } jtag_rsp_t;

        // TAP controller states in the classic 1149.1 encoding
        typedef enum logic [3:0] {
                st_exit2_dr  = 4'h0,
                st_exit1_dr  = 4'h1,
                st_shift_dr  = 4'h2,
                st_pause_dr  = 4'h3,
                st_sel_ir    = 4'h4,
                st_upd_dr    = 4'h5,
                st_cap_dr    = 4'h6,
                st_sel_dr    = 4'h7,
                st_exit2_ir  = 4'h8,
                st_exit1_ir  = 4'h9,
                st_shift_ir  = 4'hA,
                st_pause_ir  = 4'hB,
                st_rti       = 4'hC,
                st_upd_ir    = 4'hD,
                st_cap_ir    = 4'hE,
                st_tlr       = 4'hF
        } tap_state_t;

endpackage

`default_nettype wire

// File: design/credit_fifo.sv
`default_nettype none

`include "jtag_macros.svh"

module credit_fifo #(
        parameter type payload_t = logic
) (
        input  logic     clk_i,
        input  logic     reset_i,
        input  logic     push_i,
        input  payload_t data_i,
        input  logic     pop_i,
        output payload_t data_o,
        output logic     empty_o,
        output logic     credit_o
);
        localparam int depth = `JTAG_FIFO_DEPTH;
        localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
        localparam int cnt_w = $clog2(depth + 1);

        payload_t         mem_q [depth];
        logic [ptr_w-1:0] wr_ptr_q;
        logic [ptr_w-1:0] rd_ptr_q;
        logic [cnt_w-1:0] count_q;
        logic             do_push;
        logic             do_pop;
        logic             credit_q;

        assign do_push = push_i && (count_q != cnt_w'(depth)); // Sender holds no credit when full
        assign do_pop  = pop_i && !empty_o;

        always_ff @(posedge clk_i) begin
                if (do_push)
                        mem_q[wr_ptr_q] <= data_i;
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                        credit_q <= 1'b0;
                end else begin
                        if (do_push)
                                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ?
                                            '0 : wr_ptr_q + ptr_w'(1);
                        if (do_pop)
                                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ?
                                            '0 : rd_ptr_q + ptr_w'(1);
                        case ({do_push, do_pop})
                                2'b10:   count_q <= count_q + cnt_w'(1);
                                2'b01:   count_q <= count_q - cnt_w'(1);
                                default: count_q <= count_q;
                        endcase
                        credit_q <= do_pop; // One credit back per entry freed
                end
        end

        assign data_o   = mem_q[rd_ptr_q];
        assign empty_o  = (count_q == '0);
        assign credit_o = credit_q;

endmodule

`default_nettype wire

// File: design/jtag_pin_driver.sv
`default_nettype none

`include "jtag_macros.svh"

module jtag_pin_driver (
        input  logic               clk_i,
        input  logic               reset_i,
        input  jtag_pkg::jtag_cmd_t cmd_i,
        input  logic               cmd_empty_i,
        output logic               cmd_pop_o,
        output jtag_pkg::jtag_pins_t pins_o,
        input  logic               tdo_i,
        input  logic               tdo_oe_i,
        input  logic               rsp_credit_i,
        output logic               rsp_valid_o,
        output jtag_pkg::jtag_rsp_t rsp_o,
        output logic               timeout_o
);
        import jtag_pkg::*;

        localparam int hold_w = $clog2(`JTAG_HOLD_CYCLES + 1);
        localparam int cred_w = $clog2(`JTAG_RSP_CREDITS + 1);
        localparam int idle_w = $clog2(`JTAG_TIMEOUT_COUNT + 1);

        jtag_pins_t        pins_q;
        logic              prev_tck_q;   // tck level of the word before the current one
        logic              active_q;     // A popped word is still in its hold window
        logic [hold_w-1:0] hold_q;
        logic              rsp_pend_q;
        jtag_rsp_t         rsp_q;
        logic [cred_w-1:0] cred_q;
        logic [idle_w-1:0] idle_q;
        logic              hold_done;
        logic              capture;
        logic              rsp_send;

        assign hold_done = (hold_q == '0);
        // Last cycle of a rising word with TDO enabled
        assign capture   = active_q && hold_done && pins_q.tck && !prev_tck_q && tdo_oe_i;
        assign rsp_send  = rsp_pend_q && (cred_q != '0);
        // Never pop while a finished bit still waits for a credit
        assign cmd_pop_o = !cmd_empty_i && hold_done && !capture && (!rsp_pend_q || rsp_send);

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        pins_q     <= '{tck: 1'b0, tms: 1'b0, tdi: 1'b0, trst: 1'b1};
                        prev_tck_q <= 1'b0;
                        active_q   <= 1'b0;
                        hold_q     <= '0;
                end else if (cmd_pop_o) begin
                        pins_q     <= '{tck: cmd_i.tck, tms: cmd_i.tms, tdi: cmd_i.tdi,
                                        trst: cmd_i.trst};
                        prev_tck_q <= pins_q.tck;
                        active_q   <= 1'b1;
                        hold_q     <= hold_w'(`JTAG_HOLD_CYCLES - 1);
                end else if (!hold_done) begin
                        hold_q <= hold_q - hold_w'(1);
                end else begin
                        active_q <= 1'b0;
                end
        end

        always_ff @(posedge clk_i) begin
                if (capture)
                        rsp_q <= '{tdo: tdo_i};
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        rsp_pend_q <= 1'b0;
                        cred_q     <= cred_w'(`JTAG_RSP_CREDITS);
                end else begin
                        if (capture)
                                rsp_pend_q <= 1'b1;
                        else if (rsp_send)
                                rsp_pend_q <= 1'b0;
                        case ({rsp_credit_i, rsp_send})
                                2'b10:   cred_q <= cred_q + cred_w'(1);
                                2'b01:   cred_q <= cred_q - cred_w'(1);
                                default: cred_q <= cred_q;
                        endcase
                end
        end

        // Starts saturated so nothing fires before the first command arrives
        always_ff @(posedge clk_i) begin
                if (reset_i)
                        idle_q <= idle_w'(`JTAG_TIMEOUT_COUNT);
                else if (!cmd_empty_i)
                        idle_q <= '0;
                else if (idle_q != idle_w'(`JTAG_TIMEOUT_COUNT))
                        idle_q <= idle_q + idle_w'(1);
        end

        assign timeout_o   = cmd_empty_i && (idle_q == idle_w'(`JTAG_TIMEOUT_COUNT - 1));
        assign pins_o      = pins_q;
        assign rsp_valid_o = rsp_send;
        assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: design/jtag_tap_fsm.sv
`default_nettype none

module jtag_tap_fsm (
        input  logic                 clk_i,
        input  logic                 reset_i,
        input  jtag_pkg::jtag_pins_t pins_i,
        output jtag_pkg::tap_state_t state_o,
        output logic                 tck_rise_o,
        output logic                 tck_fall_o
);
        import jtag_pkg::*;

        logic       tck_q;
        logic       tck_d_q;  // tck one cycle older for edge detection
        logic       tms_q;
        logic       trst_q;
        tap_state_t state_q;
        tap_state_t state_nxt;

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        tck_q   <= 1'b0;
                        tck_d_q <= 1'b0;
                        tms_q   <= 1'b0;
                        trst_q  <= 1'b1;
                end else begin
                        tck_q   <= pins_i.tck;
                        tck_d_q <= tck_q;
                        tms_q   <= pins_i.tms;
                        trst_q  <= pins_i.trst;
                end
        end

        assign tck_rise_o = tck_q && !tck_d_q;
        assign tck_fall_o = !tck_q && tck_d_q;

        // Standard TMS-driven state diagram
        always_comb begin
                case (state_q)
                        st_tlr:      state_nxt = tms_q ? st_tlr      : st_rti;
                        st_rti:      state_nxt = tms_q ? st_sel_dr   : st_rti;
                        st_sel_dr:   state_nxt = tms_q ? st_sel_ir   : st_cap_dr;
                        st_cap_dr:   state_nxt = tms_q ? st_exit1_dr : st_shift_dr;
                        st_shift_dr: state_nxt = tms_q ? st_exit1_dr : st_shift_dr;
                        st_exit1_dr: state_nxt = tms_q ? st_upd_dr   : st_pause_dr;
                        st_pause_dr: state_nxt = tms_q ? st_exit2_dr : st_pause_dr;
                        st_exit2_dr: state_nxt = tms_q ? st_upd_dr   : st_shift_dr;
                        st_upd_dr:   state_nxt = tms_q ? st_sel_dr   : st_rti;
                        st_sel_ir:   state_nxt = tms_q ? st_tlr      : st_cap_ir;
                        st_cap_ir:   state_nxt = tms_q ? st_exit1_ir : st_shift_ir;
                        st_shift_ir: state_nxt = tms_q ? st_exit1_ir : st_shift_ir;
                        st_exit1_ir: state_nxt = tms_q ? st_upd_ir   : st_pause_ir;
                        st_pause_ir: state_nxt = tms_q ? st_exit2_ir : st_pause_ir;
                        st_exit2_ir: state_nxt = tms_q ? st_upd_ir   : st_shift_ir;
                        default:     state_nxt = tms_q ? st_sel_dr   : st_rti; // Update-IR
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (reset_i || trst_q)
                        state_q <= st_tlr; // TRST wins over any edge
                else if (tck_rise_o)
                        state_q <= state_nxt;
        end

        assign state_o = state_q;

endmodule

`default_nettype wire

// File: design/jtag_tap_regs.sv
`default_nettype none

`include "jtag_macros.svh"

module jtag_tap_regs (
        input  logic                 clk_i,
        input  logic                 reset_i,
        input  logic                 tdi_i,
        input  jtag_pkg::tap_state_t state_i,
        input  logic                 tck_rise_i,
        input  logic                 tck_fall_i,
        output logic                 tdo_o,
        output logic                 tdo_oe_o
);
        import jtag_pkg::*;

        logic [3:0]  ir_q;
        logic [3:0]  ir_sr_q;
        logic [31:0] dr_sr_q;   // Shared by IDCODE, USER and BYPASS
        logic [7:0]  user_q;
        logic        tdo_q;
        logic        tdo_oe_q;
        logic        sel_idcode;
        logic        sel_user;

        // Anything else falls back to BYPASS
        assign sel_idcode = (ir_q == `JTAG_IR_IDCODE);
        assign sel_user   = (ir_q == `JTAG_IR_USER);

        // Capture and shift on tck rise
        always_ff @(posedge clk_i) begin
                if (tck_rise_i) begin
                        case (state_i)
                                st_cap_ir:   ir_sr_q <= 4'b0001;
                                st_shift_ir: ir_sr_q <= {tdi_i, ir_sr_q[3:1]};
                                st_cap_dr: begin
                                        if (sel_idcode)
                                                dr_sr_q <= `JTAG_IDCODE;
                                        else if (sel_user)
                                                dr_sr_q <= {24'h0, user_q};
                                        else
                                                dr_sr_q <= '0;
                                end
                                st_shift_dr: begin
                                        if (sel_idcode)
                                                dr_sr_q <= {tdi_i, dr_sr_q[31:1]};
                                        else if (sel_user)
                                                dr_sr_q[7:0] <= {tdi_i, dr_sr_q[7:1]};
                                        else
                                                dr_sr_q[0] <= tdi_i; // 1-bit bypass path
                                end
                                default: ;
                        endcase
                end
        end

        // Update stage on tck fall
        always_ff @(posedge clk_i) begin
                if (reset_i || state_i == st_tlr) begin
                        ir_q <= `JTAG_IR_IDCODE;
                end else if (tck_fall_i && state_i == st_upd_ir) begin
                        ir_q <= ir_sr_q;
                end
        end

        always_ff @(posedge clk_i) begin
                if (reset_i)
                        user_q <= '0;
                else if (tck_fall_i && state_i == st_upd_dr && sel_user)
                        user_q <= dr_sr_q[7:0];
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        tdo_q    <= 1'b0;
                        tdo_oe_q <= 1'b0;
                end else if (tck_fall_i) begin
                        tdo_oe_q <= (state_i == st_shift_ir) || (state_i == st_shift_dr);
                        if (state_i == st_shift_ir)
                                tdo_q <= ir_sr_q[0];
                        else if (state_i == st_shift_dr)
                                tdo_q <= dr_sr_q[0];
                end else if (state_i == st_tlr) begin
                        tdo_oe_q <= 1'b0; // TRST drops the output enable at once
                end
        end

        assign tdo_o    = tdo_q;
        assign tdo_oe_o = tdo_oe_q;

endmodule

`default_nettype wire

// File: design/jtag_link_top.sv
`default_nettype none

module jtag_link_top (
        input  logic                clk_i,
        input  logic                reset_i,
        input  logic                cmd_valid_i,
        input  jtag_pkg::jtag_cmd_t cmd_i,
        output logic                cmd_credit_o,
        input  logic                rsp_credit_i,
        output logic                rsp_valid_o,
        output jtag_pkg::jtag_rsp_t rsp_o,
        output logic                timeout_o
);
        import jtag_pkg::*;

        jtag_cmd_t  cmd_head;   // Oldest queued word
        logic       cmd_empty;
        logic       cmd_pop;
        jtag_pins_t pins;
        logic       tdo;
        logic       tdo_oe;
        tap_state_t tap_state;
        logic       tck_rise;
        logic       tck_fall;

        credit_fifo #(
                .payload_t (jtag_cmd_t)
        ) cmd_fifo0 (
                .clk_i    (clk_i),
                .reset_i  (reset_i),
                .push_i   (cmd_valid_i),
                .data_i   (cmd_i),
                .pop_i    (cmd_pop),
                .data_o   (cmd_head),
                .empty_o  (cmd_empty),
                .credit_o (cmd_credit_o)
        );

        jtag_pin_driver driver0 (
                .clk_i        (clk_i),
                .reset_i      (reset_i),
                .cmd_i        (cmd_head),
                .cmd_empty_i  (cmd_empty),
                .cmd_pop_o    (cmd_pop),
                .pins_o       (pins),
                .tdo_i        (tdo),
                .tdo_oe_i     (tdo_oe),
                .rsp_credit_i (rsp_credit_i),
                .rsp_valid_o  (rsp_valid_o),
                .rsp_o        (rsp_o),
                .timeout_o    (timeout_o)
        );

        // Target side runs on clk_i and sees the pins directly
        jtag_tap_fsm fsm0 (
                .clk_i      (clk_i),
                .reset_i    (reset_i),
                .pins_i     (pins),
                .state_o    (tap_state),
                .tck_rise_o (tck_rise),
                .tck_fall_o (tck_fall)
        );

        jtag_tap_regs regs0 (
                .clk_i      (clk_i),
                .reset_i    (reset_i),
                .tdi_i      (pins.tdi),
                .state_i    (tap_state),
                .tck_rise_i (tck_rise),
                .tck_fall_i (tck_fall),
                .tdo_o      (tdo),
                .tdo_oe_o   (tdo_oe)
        );

endmodule

`default_nettype wire

// File: tests/jtag_link_tb.sv
`default_nettype none

`include "jtag_macros.svh"

module jtag_link_tb;
        import jtag_pkg::*;

        // One table row is one scan sequence and bit 0 goes out first
        typedef struct packed {
                logic [7:0]  nbits;
                logic [63:0] tms;
                logic [63:0] tdi;
                logic [63:0] trst;
                logic [7:0]  nexp;   // Responses the row must produce
                logic [63:0] rsp;
        } row_t;

        localparam int n_rows = 5;
        localparam logic [7:0] pat_a = 8'hA5;
        localparam logic [7:0] pat_b = 8'h3C;
        localparam logic [7:0] pat_c = 8'h96;

        logic      clk;
        logic      reset;
        logic      cmd_valid;
        jtag_cmd_t cmd;
        logic      cmd_credit;
        logic      rsp_credit;
        logic      rsp_valid;
        jtag_rsp_t rsp;
        logic      timeout;

        row_t        rows [n_rows];
        string       names [n_rows];
        logic        exp_q [$];
        logic [15:0] lfsr_q = 16'd25;
        int          cycle_n = 0;
        int          limit_n = 1_000_000;  // Replaced once the table is loaded
        int          sent_n = 0;
        int          credits_back = 0;
        int          host_credits = `JTAG_FIFO_DEPTH;
        int          got_n = 0;
        int          exp_total = 0;
        int          owed_n = 0;           // Response credits not yet returned
        int          delay_n = 0;
        int          timeout_n = 0;
        int          err_n = 0;
        int          pass_n = 0;
        int          fail_n = 0;
        string       cur_name = "reset";

        jtag_link_top dut0 (
                .clk_i        (clk),
                .reset_i      (reset),
                .cmd_valid_i  (cmd_valid),
                .cmd_i        (cmd),
                .cmd_credit_o (cmd_credit),
                .rsp_credit_i (rsp_credit),
                .rsp_valid_o  (rsp_valid),
                .rsp_o        (rsp),
                .timeout_o    (timeout)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        always @(posedge clk)
                cycle_n <= cycle_n + 1;

        initial begin
                wait (cycle_n >= limit_n);
                $display("Run stopped after %0d cycles without finishing", cycle_n);
                $display("SOME TESTS FAILED");
                $finish;
        end

        // Fibonacci LFSR with taps 16 14 13 11
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        task automatic take_bits(input int n, output int val);
                val = 0;
                for (int i = 0; i < n; i++) begin
                        val = (val << 1) | int'(lfsr_q[15]);
                        lfsr_q = lfsr_next(lfsr_q);
                end
        endtask

        task automatic load_table;
                names[0] = "idcode";       // TRST, then Shift-DR and 32 bits
                rows[0]  = '{nbits: 8'd39, tms: 64'h30_0000_0005, tdi: '0, trst: 64'h1,
                             nexp: 8'd32, rsp: 64'(`JTAG_IDCODE)};
                names[1] = "user_ir";
                rows[1]  = '{nbits: 8'd10, tms: 64'h183, tdi: 64'(`JTAG_IR_USER) << 4,
                             trst: '0, nexp: 8'd4, rsp: 64'(4'b0001)};
                names[2] = "user_scan_a";  // Returns the reset value
                rows[2]  = '{nbits: 8'd13, tms: 64'hC01, tdi: 64'(pat_a) << 3,
                             trst: '0, nexp: 8'd8, rsp: '0};
                names[3] = "user_scan_b";
                rows[3]  = '{nbits: 8'd13, tms: 64'hC01, tdi: 64'(pat_b) << 3,
                             trst: '0, nexp: 8'd8, rsp: 64'(pat_a)};
                names[4] = "bypass";       // IR load, then an 8 bit DR scan
                rows[4]  = '{nbits: 8'd23, tms: 64'h30_0583,
                             tdi: (64'(`JTAG_IR_BYPASS) << 4) | (64'(pat_c) << 13),
                             trst: '0, nexp: 8'd12,
                             rsp: 64'(4'b0001) | (64'({pat_c[6:0], 1'b0}) << 4)};
        endtask

        task automatic check_response;
                logic exp_bit;
                assert (exp_q.size() != 0) else begin
                        $display("Response arrived in %s with none expected", cur_name);
                        err_n++;
                end
                if (exp_q.size() != 0) begin
                        exp_bit = exp_q.pop_front();
                        assert (rsp.tdo === exp_bit) else begin
                                $display("ERR %s bit %0d: expected %0b, actual %0b",
                                         cur_name, got_n, exp_bit, rsp.tdo);
                                err_n++;
                        end
                end
                got_n++;
                owed_n++;
        endtask

        // Credits go back one at a time after a random delay
        task automatic return_credit;
                rsp_credit = 1'b0;
                if (owed_n > 0) begin
                        if (delay_n == 0) begin
                                rsp_credit = 1'b1;
                                owed_n--;
                                take_bits(4, delay_n);
                        end else begin
                                delay_n--;
                        end
                end
        endtask

        task automatic tick;
                @(negedge clk);
                if (cmd_credit) begin
                        host_credits++;
                        credits_back++;
                end
                assert (credits_back <= sent_n) else begin
                        $display("Command credit returned with no command in flight");
                        err_n++;
                end
                if (rsp_valid)
                        check_response();
                if (timeout)
                        timeout_n++;
                return_credit();
        endtask

        task automatic send_cmd(input jtag_cmd_t c);
                while (host_credits == 0)
                        tick();
                cmd       = c;
                cmd_valid = 1'b1;
                host_credits--;
                sent_n++;
                tick();
                cmd_valid = 1'b0;
        endtask

        task automatic report_test(input string name, input int snap);
                if (err_n == snap) begin
                        pass_n++;
                        $display("%s: pass", name);
                end else begin
                        fail_n++;
                        $display("%s: fail with %0d errors", name, err_n - snap);
                end
        endtask

        task automatic apply_row(input int r);
                jtag_cmd_t c;
                int        snap;
                snap     = err_n;
                cur_name = names[r];
                for (int i = 0; i < int'(rows[r].nexp); i++)
                        exp_q.push_back(rows[r].rsp[i]);
                exp_total += int'(rows[r].nexp);
                for (int b = 0; b < int'(rows[r].nbits); b++) begin
                        c.tms  = rows[r].tms[b];
                        c.tdi  = rows[r].tdi[b];
                        c.trst = rows[r].trst[b];
                        c.tck  = 1'b0;
                        send_cmd(c);
                        c.tck  = 1'b1; // Rising word where the TAP acts
                        send_cmd(c);
                end
                while (got_n < exp_total)
                        tick();
                report_test(names[r], snap);
        endtask

        initial begin
                int snap;
                int t0;
                int cmd_total;
                reset      = 1'b1;
                cmd_valid  = 1'b0;
                cmd        = '0;
                rsp_credit = 1'b0;
                load_table();
                cmd_total = 0;
                for (int r = 0; r < n_rows; r++)
                        cmd_total += 2 * int'(rows[r].nbits);
                limit_n = cmd_total * (`JTAG_HOLD_CYCLES + 2) + 500;
                repeat (16) @(negedge clk);
                reset = 1'b0;

                snap = err_n;
                repeat (`JTAG_TIMEOUT_COUNT + 10) begin
                        tick();
                        assert (!cmd_credit && !rsp_valid && !timeout) else begin
                                $display("ERR reset: expected 000, actual %0b%0b%0b",
                                         cmd_credit, rsp_valid, timeout);
                                err_n++;
                        end
                end
                report_test("reset", snap);

                for (int r = 0; r < n_rows; r++)
                        apply_row(r);

                snap     = err_n;
                cur_name = "flow_control";
                while (credits_back < sent_n)
                        tick();
                t0 = timeout_n;
                repeat (`JTAG_TIMEOUT_COUNT + `JTAG_HOLD_CYCLES + 8)
                        tick();
                assert (t0 == 0) else begin
                        $display("ERR flow_control: expected 0 timeout pulses, actual %0d", t0);
                        err_n++;
                end
                assert (host_credits == `JTAG_FIFO_DEPTH) else begin
                        $display("ERR flow_control: expected %0d command credits, actual %0d",
                                 `JTAG_FIFO_DEPTH, host_credits);
                        err_n++;
                end
                assert (got_n == exp_total && exp_q.size() == 0) else begin
                        $display("ERR flow_control: expected %0d responses, actual %0d",
                                 exp_total, got_n);
                        err_n++;
                end
                report_test("flow_control", snap);

                snap = err_n;
                assert (timeout_n - t0 == 1) else begin
                        $display("ERR idle_timeout: expected 1 pulse, actual %0d",
                                 timeout_n - t0);
                        err_n++;
                end
                report_test("idle_timeout", snap);

                $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                         pass_n + fail_n, pass_n, fail_n, err_n);
                if (err_n == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/jtag_pkg.sv
design/credit_fifo.sv
design/jtag_pin_driver.sv
design/jtag_tap_fsm.sv
design/jtag_tap_regs.sv
design/jtag_link_top.sv
tests/jtag_link_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the JTAG link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module jtag_link_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vjtag_link_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
